//--- hdl/la_pkg.sv
// la32 core shared types
// and host address map
`default_nettype none

package la_pkg;

    ////////////////////////////////////////
    // alu operations
    ////////////////////////////////////////
    // codes follow inst[18:15] of the 3R group
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd2,
        alu_sra  = 4'd3,    // no slot in the 3R field, borrowed
        alu_slt  = 4'd4,
        alu_sltu = 4'd5,
        alu_nor  = 4'd8,
        alu_and  = 4'd9,
        alu_or   = 4'd10,
        alu_xor  = 4'd11,
        alu_sll  = 4'd14,
        alu_srl  = 4'd15
    } alu_op_t;

    // operand 1 source
    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_pc   = 2'd1,   // pcaddu12i
        src1_zero = 2'd2    // lu12i.w
    } src1_t;

    // operand 2 source
    typedef enum logic {
        src2_rf  = 1'b0,
        src2_imm = 1'b1
    } src2_t;

    // issue sequencer in the bus port
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_exec   = 2'd1,
        st_commit = 2'd2,
        st_done   = 2'd3    // ack cycle
    } port_state_t;

    ////////////////////////////////////////
    // constants
    ////////////////////////////////////////
    localparam logic [31:0] RESET_PC      = 32'h1c00_0000;

    // byte addresses on the wishbone port
    localparam logic [8:0]  ADDR_REG_LAST = 9'h07c;  // r0..r31 at 0x00..0x7c
    localparam logic [8:0]  ADDR_PC       = 9'h080;  // read only
    localparam logic [8:0]  ADDR_STATUS   = 9'h084;  // read only
    localparam logic [8:0]  ADDR_ISSUE    = 9'h100;  // write only

endpackage

`default_nettype wire

//--- hdl/la_decoder.sv
// la32 instruction decoder
`default_nettype none

module la_decoder (
    input  wire logic [31:0]  inst,
    output la_pkg::alu_op_t   alu_op,
    output la_pkg::src1_t     src1_sel,
    output la_pkg::src2_t     src2_sel,
    output logic [31:0]       imm,
    output logic [4:0]        rd,
    output logic [4:0]        rj,
    output logic [4:0]        rk,
    output logic              illegal
);

    ////////////////////////////////////////
    // group match
    ////////////////////////////////////////
    logic is_alu;       // 3R group, op in inst[18:15]
    logic is_sra;       // sra.w sits outside that field
    logic is_sfti;      // slli/srli/srai
    logic is_alu_imm;   // 2RI12 arith and logic
    logic is_lui;
    logic is_pcadd;
    logic sub_bad;      // group hit but sub-code not kept
    logic is_i12;
    logic is_u12;
    logic is_i20;

    assign is_alu     = inst[30:19] == 12'b0000_0000_0010;
    assign is_sra     = inst[30:15] == 16'b0000_0000_0011_0000;
    assign is_sfti    = inst[30:20] == 11'b000_0000_0100 && inst[17:15] == 3'b001;
    assign is_alu_imm = inst[30:25] == 6'b00_0001;
    assign is_lui     = inst[30:25] == 6'b00_1010;
    assign is_pcadd   = inst[30:25] == 6'b00_1110;

    ////////////////////////////////////////
    // alu op select
    ////////////////////////////////////////
    always_comb begin
        alu_op  = la_pkg::alu_add;  // lu12i and pcaddu12i just add
        sub_bad = 1'b0;
        if (is_alu) begin
            case (inst[18:15])
                4'd0, 4'd2, 4'd4, 4'd5, 4'd8, 4'd9, 4'd10, 4'd11, 4'd14, 4'd15:
                    alu_op = la_pkg::alu_op_t'(inst[18:15]);
                // la64 .d forms, masks, orn, andn
                default: sub_bad = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = la_pkg::alu_sra;
        end else if (is_sfti) begin
            case (inst[19:18])
                2'b00:   alu_op = la_pkg::alu_sll;
                2'b01:   alu_op = la_pkg::alu_srl;
                2'b10:   alu_op = la_pkg::alu_sra;
                default: sub_bad = 1'b1;
            endcase
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000:  alu_op = la_pkg::alu_slt;     // slti
                3'b001:  alu_op = la_pkg::alu_sltu;    // sltui
                3'b010:  alu_op = la_pkg::alu_add;     // addi.w
                3'b101:  alu_op = la_pkg::alu_and;     // andi
                3'b110:  alu_op = la_pkg::alu_or;      // ori
                3'b111:  alu_op = la_pkg::alu_xor;     // xori
                default: sub_bad = 1'b1;               // addi.d, lu52i.d
            endcase
        end
    end

    ////////////////////////////////////////
    // operand sources
    ////////////////////////////////////////
    assign src1_sel = is_lui   ? la_pkg::src1_zero :
                      is_pcadd ? la_pkg::src1_pc   : la_pkg::src1_rf;

    assign src2_sel = (is_alu_imm || is_sfti || is_lui || is_pcadd) ?
                      la_pkg::src2_imm : la_pkg::src2_rf;

    ////////////////////////////////////////
    // immediates
    ////////////////////////////////////////
    // ui5 of the shifts rides along as si12, exec keeps the low 5 bits
    assign is_i12 = (is_alu_imm & ~inst[24]) | is_sfti;   // slti, sltui, addi.w
    assign is_u12 = is_alu_imm & inst[24];                 // andi, ori, xori
    assign is_i20 = is_lui | is_pcadd;

    assign imm = ({{20{inst[21]}}, inst[21:10]} & {32{is_i12}}) |
                 ({20'd0, inst[21:10]}          & {32{is_u12}}) |
                 ({inst[24:5], 12'd0}           & {32{is_i20}});

    ////////////////////////////////////////
    // register numbers
    ////////////////////////////////////////
    assign rd = inst[4:0];
    assign rj = (is_lui || is_pcadd) ? 5'd0 : inst[9:5];   // 1RI20 has no rj
    assign rk = (is_alu || is_sra) ? inst[14:10] : 5'd0;   // only 3R reads rk

    // bit 31 never set on a kept word
    assign illegal = inst[31] || sub_bad ||
                     !(is_alu || is_sra || is_sfti || is_alu_imm || is_lui || is_pcadd);

endmodule

`default_nettype wire

//--- hdl/la_exec.sv
// la32 execute stage
`default_nettype none

module la_exec (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            exec_go,    // one cycle, from the port
    input  wire la_pkg::alu_op_t alu_op,
    input  wire la_pkg::src1_t   src1_sel,
    input  wire la_pkg::src2_t   src2_sel,
    input  wire logic [31:0]     imm,
    input  wire logic [4:0]      rd,
    input  wire logic            illegal,
    input  wire logic [31:0]     pc,
    input  wire logic [31:0]     rj_data,
    input  wire logic [31:0]     rk_data,
    output logic [31:0]          result,
    output logic [4:0]           res_rd,
    output logic                 res_illegal,
    output logic                 res_valid
);

    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;
    logic [31:0] alu_out;

    // operand muxes
    always_comb begin
        case (src1_sel)
            la_pkg::src1_rf: op1 = rj_data;
            la_pkg::src1_pc: op1 = pc;         // pc of this instruction
            default:         op1 = 32'd0;
        endcase
    end

    assign op2   = (src2_sel == la_pkg::src2_imm) ? imm : rk_data;
    assign shamt = op2[4:0];   // .w shifts use 5 bits only

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    always_comb begin
        case (alu_op)
            la_pkg::alu_add:  alu_out = op1 + op2;
            la_pkg::alu_sub:  alu_out = op1 - op2;
            la_pkg::alu_slt:  alu_out = {31'd0, $signed(op1) < $signed(op2)};
            la_pkg::alu_sltu: alu_out = {31'd0, op1 < op2};
            la_pkg::alu_nor:  alu_out = ~(op1 | op2);
            la_pkg::alu_and:  alu_out = op1 & op2;
            la_pkg::alu_or:   alu_out = op1 | op2;
            la_pkg::alu_xor:  alu_out = op1 ^ op2;
            la_pkg::alu_sll:  alu_out = op1 << shamt;
            la_pkg::alu_srl:  alu_out = op1 >> shamt;
            la_pkg::alu_sra:  alu_out = $unsigned($signed(op1) >>> shamt);
            default:          alu_out = 32'd0;
        endcase
    end

    // result register, loaded once per issue
    always_ff @(posedge clk) begin
        if (exec_go) begin
            result      <= alu_out;
            res_rd      <= rd;
            res_illegal <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= exec_go;   // commit sees it next cycle
        end
    end

endmodule

`default_nettype wire

//--- hdl/la_commit.sv
// la32 register file, pc and status
`default_nettype none

module la_commit (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        res_valid,
    input  wire logic [31:0] result,
    input  wire logic [4:0]  res_rd,
    input  wire logic        res_illegal,
    input  wire logic        bus_wr,      // host register write
    input  wire logic [4:0]  bus_wr_idx,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [4:0]  rj,
    input  wire logic [4:0]  rk,
    input  wire logic [4:0]  rd_idx,      // host read index
    output logic [31:0]      rj_data,
    output logic [31:0]      rk_data,
    output logic [31:0]      rd_data,
    output logic [31:0]      pc,
    output logic [31:0]      status
);

    logic [31:0] rf [0:31];
    logic [31:0] rf_written;    // per entry, cleared by reset, bit 0 never set
    logic        rf_we;
    logic [4:0]  rf_widx;
    logic [31:0] rf_wdata;
    logic [15:0] retired;
    logic        sticky_ill;

    ////////////////////////////////////////
    // single write port
    ////////////////////////////////////////
    // port never issues a host write while a result is pending
    always_comb begin
        rf_we    = 1'b0;
        rf_widx  = res_rd;
        rf_wdata = result;
        if (res_valid) begin
            rf_we = !res_illegal && res_rd != 5'd0;
        end else if (bus_wr) begin
            rf_we    = bus_wr_idx != 5'd0;   // r0 writes dropped
            rf_widx  = bus_wr_idx;
            rf_wdata = wb_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rf_widx] <= rf_wdata;
        end
    end

    // unwritten entries read as zero
    assign rj_data = rf_written[rj]     ? rf[rj]     : 32'd0;
    assign rk_data = rf_written[rk]     ? rf[rk]     : 32'd0;
    assign rd_data = rf_written[rd_idx] ? rf[rd_idx] : 32'd0;

    ////////////////////////////////////////
    // pc, retire count, sticky flag
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            rf_written <= 32'd0;
            pc         <= la_pkg::RESET_PC;
            retired    <= 16'd0;
            sticky_ill <= 1'b0;
        end else begin
            if (rf_we) begin
                rf_written[rf_widx] <= 1'b1;
            end
            if (res_valid) begin
                pc         <= pc + 32'd4;           // illegal words advance too
                retired    <= retired + 16'd1;
                sticky_ill <= sticky_ill | res_illegal;
            end
        end
    end

    assign status = {retired, 15'd0, sticky_ill};

endmodule

`default_nettype wire

//--- hdl/la_bus_port.sv
// la32 wishbone classic slave port
`default_nettype none

module la_bus_port (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [8:0]  wb_adr,      // byte address
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [31:0] rd_data,
    input  wire logic [31:0] pc,
    input  wire logic [31:0] status,
    output logic             wb_ack,
    output logic [31:0]      wb_dat_o,
    output logic [31:0]      inst,
    output logic             exec_go,
    output logic             bus_wr,
    output logic [4:0]       bus_wr_idx,
    output logic [4:0]       rd_idx
);

    la_pkg::port_state_t state;
    logic        req;          // new transfer seen in idle
    logic        reg_hit;
    logic        issue_hit;
    logic [31:0] rdata_mux;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    // ack still high means the master has not dropped stb yet
    assign req       = state == la_pkg::st_idle && wb_cyc && wb_stb && !wb_ack;
    assign reg_hit   = wb_adr <= la_pkg::ADDR_REG_LAST;
    assign issue_hit = wb_adr == la_pkg::ADDR_ISSUE;

    assign rd_idx     = wb_adr[6:2];
    assign bus_wr_idx = wb_adr[6:2];
    assign bus_wr     = req && wb_we && reg_hit;   // lands on the edge raising ack
    assign exec_go    = state == la_pkg::st_exec;

    always_comb begin
        if (reg_hit) begin
            rdata_mux = rd_data;
        end else if (wb_adr == la_pkg::ADDR_PC) begin
            rdata_mux = pc;
        end else if (wb_adr == la_pkg::ADDR_STATUS) begin
            rdata_mux = status;
        end else begin
            rdata_mux = 32'd0;   // unmapped
        end
    end

    ////////////////////////////////////////
    // issue sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= la_pkg::st_idle;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            case (state)
                la_pkg::st_idle: begin
                    if (req && wb_we && issue_hit) begin
                        state <= la_pkg::st_exec;
                    end else if (req) begin
                        wb_ack <= 1'b1;     // plain read or write
                    end
                end
                la_pkg::st_exec:   state <= la_pkg::st_commit;
                la_pkg::st_commit: begin
                    state  <= la_pkg::st_done;
                    wb_ack <= 1'b1;
                end
                default:           state <= la_pkg::st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rdata_mux;   // valid in the ack cycle
        end
        if (req && wb_we && issue_hit) begin
            inst <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/la_core.sv
// la32 core top
`default_nettype none

module la_core (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [8:0]  wb_adr,
    input  wire logic [31:0] wb_dat_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack
);

    // port side
    logic [31:0]      inst;
    logic             exec_go;
    logic             bus_wr;
    logic [4:0]       bus_wr_idx;
    logic [4:0]       rd_idx;
    // decode
    la_pkg::alu_op_t  alu_op;
    la_pkg::src1_t    src1_sel;
    la_pkg::src2_t    src2_sel;
    logic [31:0]      imm;
    logic [4:0]       rd;
    logic [4:0]       rj;
    logic [4:0]       rk;
    logic             illegal;
    // execute result
    logic [31:0]      result;
    logic [4:0]       res_rd;
    logic             res_illegal;
    logic             res_valid;
    // register file and state
    logic [31:0]      rj_data;
    logic [31:0]      rk_data;
    logic [31:0]      rd_data;
    logic [31:0]      pc;
    logic [31:0]      status;

    la_bus_port port0 (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i,
        .rd_data, .pc, .status, .wb_ack, .wb_dat_o, .inst, .exec_go,
        .bus_wr, .bus_wr_idx, .rd_idx
    );

    la_decoder dec0 (
        .inst, .alu_op, .src1_sel, .src2_sel, .imm, .rd, .rj, .rk, .illegal
    );

    la_exec exec0 (
        .clk, .reset, .exec_go, .alu_op, .src1_sel, .src2_sel, .imm, .rd,
        .illegal, .pc, .rj_data, .rk_data, .result, .res_rd, .res_illegal,
        .res_valid
    );

    la_commit commit0 (
        .clk, .reset, .res_valid, .result, .res_rd, .res_illegal, .bus_wr,
        .bus_wr_idx, .wb_dat_i, .rj, .rk, .rd_idx, .rj_data, .rk_data,
        .rd_data, .pc, .status
    );

endmodule

`default_nettype wire

//--- tb/la_core_assert.sv
// wishbone port protocol checks
`default_nettype none

module la_core_assert (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                wb_cyc,
    input wire logic                wb_stb,
    input wire logic                wb_ack,
    input wire logic                exec_go,
    input wire la_pkg::port_state_t state
);

    // ack lasts one cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

    // ack answers a live request
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without cyc and stb");

    // issue runs exec, commit, then acks from done
    issue_to_ack: assert property (@(posedge clk) disable iff (reset)
        $past(exec_go, 2) |-> wb_ack && state == la_pkg::st_done)
        else $error("no issue ack two cycles after exec_go");

endmodule

bind la_bus_port la_core_assert asrt0 (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_ack, .exec_go, .state
);

`default_nettype wire

//--- tb/tb_la_core.sv
// la32 core testbench
`default_nettype none

module tb_la_core;

    typedef struct packed {
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [31:0] exp;
        logic        ill;      // sticky flag expected after this row
    } row_t;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [8:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    row_t        tbl [$];      // stimulus and expected values
    logic [31:0] mdl [0:31];   // reference register file
    logic [31:0] mdl_pc;
    logic        mdl_ill;
    logic [31:0] rng;

    la_core dut0 (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i,
        .wb_dat_o, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("ERROR t=%0t %s expected %08h actual %08h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("ERROR t=%0t %s expected %0b actual %0b",
                                $time, name, exp, act));
        end
    endtask

    ////////////////////////////////////////
    // wishbone master
    ////////////////////////////////////////
    task automatic wait_ack(input string what);
        int n;
        n = 0;
        while (wb_ack !== 1'b1 && n < 20) begin
            @(posedge clk);
            #1;                         // ack and data settled by now
            n++;
        end
        if (wb_ack !== 1'b1) begin
            fail_stop($sformatf("timeout, no ack for %s", what));
        end
    endtask

    task automatic wb_write(input logic [8:0] adr, input logic [31:0] dat);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = dat;
        wait_ack($sformatf("write to 0x%03h", adr));
        wb_cyc   = 1'b0;                // stb low for the next edge
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
    endtask

    task automatic wb_read(input logic [8:0] adr, output logic [31:0] dat);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack($sformatf("read of 0x%03h", adr));
        dat    = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    function automatic logic [8:0] reg_adr(input logic [4:0] idx);
        return {2'b00, idx, 2'b00};     // one word per register
    endfunction

    // host register write, model follows
    task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
        wb_write(reg_adr(idx), val);
        if (idx != 5'd0) begin
            mdl[idx] = val;
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    // keyed by the 3R opcode in bits 31:15
    function automatic logic [31:0] reg_model(input logic [16:0] opc,
                                              input logic [31:0] a, input logic [31:0] b);
        case (opc)
            17'h20:  return a + b;
            17'h22:  return a - b;
            17'h24:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            17'h25:  return (a < b) ? 32'd1 : 32'd0;
            17'h28:  return ~(a | b);
            17'h29:  return a & b;
            17'h2a:  return a | b;
            17'h2b:  return a ^ b;
            17'h2e:  return a << b[4:0];
            17'h2f:  return a >> b[4:0];
            default: return $unsigned($signed(a) >>> b[4:0]);   // sra.w
        endcase
    endfunction

    task automatic push_row(input logic [31:0] inst, input logic [4:0] rd,
                            input logic [31:0] val, input logic bad);
        row_t r;
        if (bad) begin
            mdl_ill = 1'b1;             // no write, flag sticks
        end else if (rd != 5'd0) begin
            mdl[rd] = val;
        end
        r.inst = inst;
        r.rd   = rd;
        r.exp  = mdl[rd];
        r.ill  = mdl_ill;
        tbl.push_back(r);
        mdl_pc = mdl_pc + 32'd4;        // every word retires
    endtask

    task automatic add_reg_op(input logic [16:0] opc, input logic [4:0] rd,
                              input logic [4:0] rj, input logic [4:0] rk);
        push_row({opc, rk, rj, rd}, rd, reg_model(opc, mdl[rj], mdl[rk]), 1'b0);
    endtask

    task automatic add_imm_op(input logic [9:0] opc, input logic [4:0] rd,
                              input logic [4:0] rj, input logic [11:0] i12);
        logic [31:0] s;
        logic [31:0] z;
        logic [31:0] v;
        s = {{20{i12[11]}}, i12};       // slti, sltui, addi.w
        z = {20'd0, i12};               // andi, ori, xori
        case (opc)
            10'h008: v = reg_model(17'h24, mdl[rj], s);
            10'h009: v = reg_model(17'h25, mdl[rj], s);
            10'h00a: v = mdl[rj] + s;
            10'h00d: v = mdl[rj] & z;
            10'h00e: v = mdl[rj] | z;
            default: v = mdl[rj] ^ z;
        endcase
        push_row({opc, i12, rj, rd}, rd, v, 1'b0);
    endtask

    task automatic add_shift_op(input logic [16:0] opc, input logic [16:0] mop,
                                input logic [4:0] rd, input logic [4:0] rj,
                                input logic [4:0] ui5);
        push_row({opc, ui5, rj, rd}, rd, reg_model(mop, mdl[rj], {27'd0, ui5}), 1'b0);
    endtask

    task automatic add_u20_op(input logic [6:0] opc, input logic [4:0] rd,
                              input logic [19:0] si20);
        logic [31:0] v;
        v = {si20, 12'd0};
        if (opc == 7'h0e) begin
            v = v + mdl_pc;             // pcaddu12i, pc of this word
        end
        push_row({opc, si20, rd}, rd, v, 1'b0);
    endtask

    task automatic add_bad_word(input logic [31:0] word);
        push_row(word, word[4:0], 32'd0, 1'b1);
    endtask

    task automatic build_table();
        add_reg_op(17'h20, 5'd11, 5'd1, 5'd2);      // add.w
        add_reg_op(17'h22, 5'd12, 5'd3, 5'd4);      // sub.w
        add_reg_op(17'h24, 5'd13, 5'd9, 5'd1);      // slt
        add_reg_op(17'h25, 5'd14, 5'd9, 5'd1);      // sltu, -5 is huge
        add_reg_op(17'h28, 5'd15, 5'd5, 5'd6);      // nor
        add_reg_op(17'h29, 5'd16, 5'd7, 5'd8);      // and
        add_reg_op(17'h2a, 5'd17, 5'd1, 5'd3);      // or
        add_reg_op(17'h2b, 5'd18, 5'd2, 5'd4);      // xor
        add_reg_op(17'h2e, 5'd19, 5'd5, 5'd10);     // sll.w by 40, masked to 8
        add_reg_op(17'h2f, 5'd20, 5'd9, 5'd10);     // srl.w
        add_reg_op(17'h30, 5'd21, 5'd9, 5'd2);      // sra.w, random amount
        add_reg_op(17'h20, 5'd0, 5'd1, 5'd2);       // r0 target dropped
        add_imm_op(10'h008, 5'd22, 5'd9, 12'hfff);  // slti -5 < -1
        add_imm_op(10'h009, 5'd23, 5'd1, 12'h800);  // sltui vs 0xfffff800
        add_imm_op(10'h00a, 5'd24, 5'd9, 12'h800);  // addi.w -2048
        add_imm_op(10'h00d, 5'd25, 5'd1, 12'hfff);  // andi
        add_imm_op(10'h00e, 5'd26, 5'd2, 12'h8a5);  // ori
        add_imm_op(10'h00f, 5'd27, 5'd3, 12'hf0f);  // xori
        add_imm_op(10'h00a, 5'd0, 5'd1, 12'h005);
        add_shift_op(17'h81, 17'h2e, 5'd28, 5'd1, 5'd31);   // slli.w
        add_shift_op(17'h89, 17'h2f, 5'd29, 5'd9, 5'd4);    // srli.w
        add_shift_op(17'h91, 17'h30, 5'd30, 5'd9, 5'd1);    // srai.w
        add_u20_op(7'h0a, 5'd31, 20'h80001);        // lu12i.w
        add_u20_op(7'h0e, 5'd5, 20'hfffff);         // pcaddu12i backwards
        add_u20_op(7'h0e, 5'd6, 20'h00010);
        add_reg_op(17'h20, 5'd7, 5'd31, 5'd5);      // reads two fresh results
        add_bad_word(32'h8010_0441);                // bit 31 on an add.w
        add_reg_op(17'h20, 5'd8, 5'd1, 5'd2);       // flag holds
        add_bad_word(32'h5800_0c22);                // beq
        add_bad_word(32'h2880_0083);                // ld.w
        add_bad_word(32'h02c0_1484);                // addi.d sub-code
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int i;
        logic [31:0] rdat;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 9'd0;
        wb_dat_i = 32'd0;
        rng      = 32'd82629;
        mdl_pc   = la_pkg::RESET_PC;
        mdl_ill  = 1'b0;
        for (i = 0; i < 32; i++) begin
            mdl[i] = 32'd0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // state right after reset
        wb_read(la_pkg::ADDR_PC, rdat);
        check_word("pc", la_pkg::RESET_PC, rdat);
        wb_read(la_pkg::ADDR_STATUS, rdat);
        check_word("status", 32'd0, rdat);
        for (i = 0; i < 32; i += 7) begin
            wb_read(reg_adr(5'(i)), rdat);
            check_word($sformatf("r%0d", i), 32'd0, rdat);
        end

        // host write to r0 is dropped
        set_reg(5'd0, 32'hdead_beef);
        wb_read(reg_adr(5'd0), rdat);
        check_word("r0", 32'd0, rdat);

        // operands, r9 and r10 fixed for sign and shift corners
        for (i = 1; i <= 8; i++) begin
            rng = xorshift(rng);
            set_reg(5'(i), rng);
        end
        set_reg(5'd9, 32'hffff_fffb);
        set_reg(5'd10, 32'd40);

        build_table();
        foreach (tbl[k]) begin
            wb_write(la_pkg::ADDR_ISSUE, tbl[k].inst);
            wb_read(reg_adr(tbl[k].rd), rdat);
            check_word($sformatf("r%0d row %0d", tbl[k].rd, k), tbl[k].exp, rdat);
            wb_read(la_pkg::ADDR_STATUS, rdat);
            check_flag($sformatf("status.illegal row %0d", k), tbl[k].ill, rdat[0]);
        end

        // pc and retire count after the table
        wb_read(la_pkg::ADDR_PC, rdat);
        check_word("pc", mdl_pc, rdat);
        wb_read(la_pkg::ADDR_STATUS, rdat);
        check_word("status.retired", 32'(tbl.size()), {16'd0, rdat[31:16]});
        wb_read(reg_adr(5'd0), rdat);
        check_word("r0", 32'd0, rdat);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/la_pkg.sv
hdl/la_decoder.sv
hdl/la_exec.sv
hdl/la_commit.sv
hdl/la_bus_port.sv
hdl/la_core.sv
tb/la_core_assert.sv
tb/tb_la_core.sv

//--- run.sh
#!/bin/sh
# build and run the la32 core testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_la_core -f sources.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST OK" ||
{ echo "simulation did not pass"; exit 1; }
